/* list.f */
common/vector_pkg.sv
rtl/lead_zero_count.sv
vaddsub/vaddsub_align.sv
vaddsub/vaddsub_normalize.sv
vaddsub/vaddsub_round.sv
vaddsub/vaddsub.sv
bench/vaddsub_checker.sv
bench/vaddsub_tb.sv

/* Makefile */
# Verilator build and run of the vaddsub testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  --top-module vaddsub_tb -f list.f -o vaddsub_sim
	./obj_dir/vaddsub_sim | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* bench/vaddsub_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module vaddsub_tb
  import vector_pkg::*;
();

  localparam int DRAIN_LIMIT = 20;
  localparam int CLEAR_LIMIT = 8;

  logic  CLK;
  logic  nRST;
  logic  enable;
  logic  sub;
  fp16_t port_a;
  fp16_t port_b;
  fp16_t out;
  logic  overflow;

  int          cyc;
  int          checks;
  int          errors;
  bit          hung;
  logic [31:0] lcg_state;

  // expected results in issue order with the cycle each is due
  int          due_q[$];
  logic [15:0] out_q[$];
  logic        ovf_q[$];

  vaddsub dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .enable   (enable),
    .sub      (sub),
    .port_a   (port_a),
    .port_b   (port_b),
    .out      (out),
    .overflow (overflow)
  );

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // nonzero finite normal word with exponent 1..30
  function automatic logic [15:0] random_normal();
    logic [31:0] w;
    logic [4:0]  e;
    w = lcg_next();
    e = (w[30:26] % 5'd30) + 5'd1;
    return {w[31], e, w[25:16]};
  endfunction

  task automatic check(string name, logic [15:0] expected, logic [15:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERR t=%0t %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // compare the slot against the oldest pending result, or against zero when idle
  task automatic score_slot();
    if (due_q.size() > 0 && due_q[0] == cyc) begin
      check("out", out_q[0], out.raw);
      check("overflow", {15'b0, ovf_q[0]}, {15'b0, overflow});
      void'(due_q.pop_front());
      void'(out_q.pop_front());
      void'(ovf_q.pop_front());
    end else begin
      check("out", 16'h0000, out.raw);
      check("overflow", 16'h0000, {15'b0, overflow});
    end
  endtask

  task automatic tick();
    @(posedge CLK);
    #2;  // drive point with outputs settled
    cyc++;
    score_slot();
  endtask

  // result shows on the third edge after the drive
  task automatic issue(logic [15:0] a, logic [15:0] b, logic op_sub,
                       logic [15:0] res, logic ovf);
    enable     = 1'b1;
    sub        = op_sub;
    port_a.raw = a;
    port_b.raw = b;
    due_q.push_back(cyc + 3);
    out_q.push_back(res);
    ovf_q.push_back(ovf);
    tick();
  endtask

  task automatic drain();
    int n;
    n = 0;
    enable = 1'b0;
    while (due_q.size() > 0 && !hung) begin
      if (n == DRAIN_LIMIT) begin
        $display("timeout: %0d results still pending after %0d cycles", due_q.size(), n);
        hung = 1'b1;
      end else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic wait_clear();
    int n;
    n = 0;
    while ((out.raw != 16'h0000 || overflow) && !hung) begin
      if (n == CLEAR_LIMIT) begin
        $display("timeout: out and overflow did not clear under reset");
        hung = 1'b1;
      end else begin
        tick();
        n++;
      end
    end
  endtask

  task automatic report(string name, int err0);
    $display("%s done, %0d mismatches", name, errors - err0);
  endtask

  task automatic exact_arith();
    int err0;
    err0 = errors;
    issue(16'h3C00, 16'h3C00, 1'b0, 16'h4000, 1'b0);  // 1 + 1
    issue(16'h4000, 16'h3C00, 1'b1, 16'h3C00, 1'b0);  // 2 - 1
    issue(16'h0001, 16'h0001, 1'b0, 16'h0002, 1'b0);  // subnormals
    issue(16'h3C00, 16'hBC00, 1'b0, 16'h0000, 1'b0);  // cancels to +0
    drain();
    report("exact", err0);
  endtask

  // 1.0 plus half, three quarters and one and a half ulp
  task automatic rounding();
    int err0;
    err0 = errors;
    issue(16'h3C00, 16'h1000, 1'b0, 16'h3C00, 1'b0);  // tie stays even
    issue(16'h3C00, 16'h1200, 1'b0, 16'h3C01, 1'b0);  // above half rounds up
    issue(16'h3C00, 16'h1600, 1'b0, 16'h3C02, 1'b0);  // tie 3c01/3c02
    drain();
    report("rounding", err0);
  endtask

  task automatic specials();
    int err0;
    err0 = errors;
    issue(16'h7E00, 16'h3C00, 1'b0, FP16_QNAN, 1'b0);
    issue(16'h7C00, 16'h7C00, 1'b1, FP16_QNAN, 1'b0);  // inf - inf
    issue(16'h7C00, 16'hC000, 1'b0, 16'h7C00, 1'b0);
    issue(16'h3C00, 16'h7C00, 1'b1, 16'hFC00, 1'b0);
    drain();
    report("specials", err0);
  endtask

  task automatic overflow_cases();
    int err0;
    err0 = errors;
    issue(16'h7BFF, 16'h7BFF, 1'b0, 16'h7C00, 1'b1);  // max + max
    issue(16'hFBFF, 16'h7BFF, 1'b1, 16'hFC00, 1'b1);  // -max - max
    drain();
    report("overflow", err0);
  endtask

  task automatic random_identities();
    int          err0;
    logic [15:0] x;
    err0 = errors;
    for (int i = 0; i < 40; i++) begin
      x = random_normal();
      issue(x, x, 1'b1, 16'h0000, 1'b0);         // x - x is +0
      issue(x, 16'h0000, 1'b0, x, 1'b0);         // x + 0 is x
    end
    drain();
    report("random", err0);
  endtask

  task automatic idle_and_reset();
    int err0;
    err0 = errors;
    enable = 1'b0;
    repeat (10) tick();  // idle slots must read zero
    issue(16'h7BFF, 16'h7BFF, 1'b0, 16'h7C00, 1'b1);
    issue(16'h3C00, 16'h3C00, 1'b0, 16'h4000, 1'b0);
    issue(16'h4000, 16'h4000, 1'b0, 16'h4400, 1'b0);
    enable = 1'b0;
    nRST   = 1'b0;  // inf and overflow on out with two results still in flight
    due_q.delete();
    out_q.delete();
    ovf_q.delete();
    #1;
    wait_clear();
    tick();  // a single edge under reset
    nRST = 1'b1;
    repeat (6) tick();  // nothing stale after release
    report("idle_reset", err0);
  endtask

  initial begin
    nRST       = 1'b0;
    enable     = 1'b0;
    sub        = 1'b0;
    port_a.raw = 16'h0000;
    port_b.raw = 16'h0000;
    cyc        = 0;
    checks     = 0;
    errors     = 0;
    hung       = 1'b0;
    lcg_state  = 32'd35;
    repeat (4) @(posedge CLK);
    #2;
    nRST = 1'b1;
    wait_clear();
    exact_arith();
    rounding();
    specials();
    overflow_cases();
    random_identities();
    idle_and_reset();
    $display("checks %0d, errors %0d", checks, errors);
    if (hung || errors != 0) begin
      $display("TEST FAILED");
    end else begin
      $display("TEST PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* bench/vaddsub_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module vaddsub_checker
  import vector_pkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  enable,
  input fp16_t out,
  input logic  overflow
);

  // overflow only ever packs a signed infinity
  ovf_is_inf: assert property (@(posedge CLK) disable iff (!nRST)
    overflow |-> (out.raw == 16'h7C00 || out.raw == 16'hFC00))
    else $error("overflow with non-infinite out %h", out.raw);

  nan_is_canonical: assert property (@(posedge CLK) disable iff (!nRST)
    (out.fields.exp == EXP_W'(EXP_MAX) && out.fields.frac != '0) |-> out.raw == FP16_QNAN)
    else $error("non-canonical nan on out %h", out.raw);

  // three stages between enable and out
  out_needs_issue: assert property (@(posedge CLK) disable iff (!nRST)
    (out.raw != '0) |-> $past(enable, 3))
    else $error("out %h without an operation three cycles earlier", out.raw);

endmodule

bind vaddsub vaddsub_checker u_checker (
  .CLK      (CLK),
  .nRST     (nRST),
  .enable   (enable),
  .out      (out),
  .overflow (overflow)
);

`default_nettype wire

/* vaddsub/vaddsub.sv */
`timescale 1ns/1ns
`default_nettype none

module vaddsub
  import vector_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  enable,
  input  logic  sub,
  input  fp16_t port_a,
  input  fp16_t port_b,
  output fp16_t out,
  output logic  overflow
);

  // align -> normalize
  logic             s1_valid;
  logic             s1_special;
  fp16_t            s1_special_res;
  logic [SUM_W-1:0] s1_mag;
  logic [EXP_W-1:0] s1_exp;
  logic             s1_sign;

  // normalize -> round
  logic             s2_valid;
  logic             s2_special;
  fp16_t            s2_special_res;
  logic [EXT_W-1:0] s2_norm;
  logic [EXP_W:0]   s2_exp;
  logic             s2_sign;

  vaddsub_align u_align (
    .CLK            (CLK),
    .nRST           (nRST),
    .enable         (enable),
    .sub            (sub),
    .port_a         (port_a),
    .port_b         (port_b),
    .s1_valid       (s1_valid),
    .s1_special     (s1_special),
    .s1_special_res (s1_special_res),
    .s1_mag         (s1_mag),
    .s1_exp         (s1_exp),
    .s1_sign        (s1_sign)
  );

  vaddsub_normalize u_normalize (
    .CLK            (CLK),
    .nRST           (nRST),
    .s1_valid       (s1_valid),
    .s1_special     (s1_special),
    .s1_special_res (s1_special_res),
    .s1_mag         (s1_mag),
    .s1_exp         (s1_exp),
    .s1_sign        (s1_sign),
    .s2_valid       (s2_valid),
    .s2_special     (s2_special),
    .s2_special_res (s2_special_res),
    .s2_norm        (s2_norm),
    .s2_exp         (s2_exp),
    .s2_sign        (s2_sign)
  );

  vaddsub_round u_round (
    .CLK            (CLK),
    .nRST           (nRST),
    .s2_valid       (s2_valid),
    .s2_special     (s2_special),
    .s2_special_res (s2_special_res),
    .s2_norm        (s2_norm),
    .s2_exp         (s2_exp),
    .s2_sign        (s2_sign),
    .out            (out),
    .overflow       (overflow)
  );

endmodule

`default_nettype wire

/* vaddsub/vaddsub_round.sv */
`timescale 1ns/1ns
`default_nettype none

module vaddsub_round
  import vector_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             s2_valid,
  input  logic             s2_special,
  input  fp16_t            s2_special_res,
  input  logic [EXT_W-1:0] s2_norm,
  input  logic [EXP_W:0]   s2_exp,
  input  logic             s2_sign,
  output fp16_t            out,
  output logic             overflow
);

  logic [SIG_W-1:0] sig;
  logic             guard;
  logic             round;
  logic             sticky;
  logic             inc;
  logic             carry;
  logic [SIG_W-1:0] sig_rnd;
  logic [EXP_W:0]   exp_post;
  fp16_t            res;
  logic             ovf;

  assign sig    = s2_norm[EXT_W-1:GRS_W];
  assign guard  = s2_norm[2];
  assign round  = s2_norm[1];
  assign sticky = s2_norm[0];

  // ties go to the even significand
  assign inc = guard & (round | sticky | sig[0]);
  assign {carry, sig_rnd} = {1'b0, sig} + (SIG_W+1)'(inc);

  // a subnormal that rounds up into the hidden bit becomes exponent 1
  assign exp_post = (s2_exp == '0) ? (EXP_W+1)'(sig_rnd[SIG_W-1])
                                   : s2_exp + (EXP_W+1)'(carry);

  always_comb begin
    ovf = 1'b0;
    if (s2_special) begin
      res = s2_special_res;
    end else if (exp_post >= (EXP_W+1)'(EXP_MAX)) begin
      res.fields.sign = s2_sign;  // signed inf
      res.fields.exp  = EXP_W'(EXP_MAX);
      res.fields.frac = '0;
      ovf             = 1'b1;
    end else begin
      // exponent 0 packs as subnormal, hidden bit simply dropped
      res.fields.sign = s2_sign;
      res.fields.exp  = exp_post[EXP_W-1:0];
      res.fields.frac = sig_rnd[FRAC_W-1:0];  // zero after a carry
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      out.raw  <= '0;
      overflow <= 1'b0;
    end else begin
      out.raw  <= s2_valid ? res.raw : '0;
      overflow <= s2_valid & ovf;
    end
  end

endmodule

`default_nettype wire

/* vaddsub/vaddsub_normalize.sv */
`timescale 1ns/1ns
`default_nettype none

module vaddsub_normalize
  import vector_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             s1_valid,
  input  logic             s1_special,
  input  fp16_t            s1_special_res,
  input  logic [SUM_W-1:0] s1_mag,
  input  logic [EXP_W-1:0] s1_exp,
  input  logic             s1_sign,
  output logic             s2_valid,
  output logic             s2_special,
  output fp16_t            s2_special_res,
  output logic [EXT_W-1:0] s2_norm,
  output logic [EXP_W:0]   s2_exp,
  output logic             s2_sign
);

  logic [LZ_W-1:0]  lz;
  logic [LZ_W-1:0]  shl_want;
  logic [LZ_W-1:0]  shl;
  logic             mag_zero;
  logic             room;
  logic [SUM_W-1:0] shifted;
  logic [EXT_W-1:0] norm;
  logic [EXP_W:0]   exp_n;

  lead_zero_count u_lzc (
    .value (s1_mag),
    .count (lz)
  );

  assign mag_zero = (s1_mag == '0);

  // leading one belongs on bit EXT_W-1, one below the carry bit
  assign shl_want = lz - LZ_W'(1);
  assign room     = s1_exp > EXP_W'(shl_want);
  assign shl      = room ? shl_want : LZ_W'(s1_exp - EXP_W'(1));  // stop at subnormal
  assign shifted  = s1_mag << shl;

  always_comb begin
    if (s1_mag[SUM_W-1]) begin
      // carry out, drop one bit into sticky
      norm  = {s1_mag[SUM_W-1:2], s1_mag[1] | s1_mag[0]};
      exp_n = {1'b0, s1_exp} + (EXP_W+1)'(1);
    end else begin
      norm  = shifted[EXT_W-1:0];
      exp_n = room ? {1'b0, s1_exp - EXP_W'(shl)} : '0;
    end
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  // exact cancellation is forced to +0
  always_ff @(posedge CLK) begin
    s2_special     <= s1_special | mag_zero;
    s2_special_res <= s1_special ? s1_special_res : fp16_t'('0);
    s2_norm        <= norm;
    s2_exp         <= exp_n;
    s2_sign        <= s1_sign;
  end

endmodule

`default_nettype wire

/* vaddsub/vaddsub_align.sv */
`timescale 1ns/1ns
`default_nettype none

module vaddsub_align
  import vector_pkg::*;
(
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enable,
  input  logic             sub,
  input  fp16_t            port_a,
  input  fp16_t            port_b,
  output logic             s1_valid,
  output logic             s1_special,
  output fp16_t            s1_special_res,
  output logic [SUM_W-1:0] s1_mag,
  output logic [EXP_W-1:0] s1_exp,
  output logic             s1_sign
);

  logic             sign_a;
  logic             sign_b;
  logic             nan_a;
  logic             nan_b;
  logic             inf_a;
  logic             inf_b;
  logic [SIG_W-1:0] sig_a;
  logic [SIG_W-1:0] sig_b;
  logic [EXP_W-1:0] exp_a;
  logic [EXP_W-1:0] exp_b;
  logic             swap;
  logic [EXP_W-1:0] exp_big;
  logic [EXP_W-1:0] exp_diff;
  logic [EXT_W-1:0] ext_big;
  logic [EXT_W-1:0] ext_small;
  logic [EXT_W-1:0] shift_mask;
  logic [EXT_W-1:0] ext_shift;
  logic             sticky;
  logic             sign_big;
  logic             sign_small;
  logic             special;
  fp16_t            special_res;
  logic [SUM_W-1:0] mag;

  assign sign_a = port_a.fields.sign;
  assign sign_b = port_b.fields.sign ^ sub;  // subtract flips b

  assign nan_a = (port_a.fields.exp == EXP_W'(EXP_MAX)) && (port_a.fields.frac != '0);
  assign nan_b = (port_b.fields.exp == EXP_W'(EXP_MAX)) && (port_b.fields.frac != '0);
  assign inf_a = (port_a.fields.exp == EXP_W'(EXP_MAX)) && (port_a.fields.frac == '0);
  assign inf_b = (port_b.fields.exp == EXP_W'(EXP_MAX)) && (port_b.fields.frac == '0);

  // hidden bit only for normals, subnormals behave as exponent 1
  assign sig_a = {port_a.fields.exp != '0, port_a.fields.frac};
  assign sig_b = {port_b.fields.exp != '0, port_b.fields.frac};
  assign exp_a = (port_a.fields.exp == '0) ? EXP_W'(1) : port_a.fields.exp;
  assign exp_b = (port_b.fields.exp == '0) ? EXP_W'(1) : port_b.fields.exp;

  always_comb begin
    special         = 1'b1;
    special_res.raw = FP16_QNAN;
    if (nan_a || nan_b || (inf_a && inf_b && (sign_a != sign_b))) begin
      special_res.raw = FP16_QNAN;  // inf - inf lands here too
    end else if (inf_a) begin
      special_res.fields.sign = sign_a;
      special_res.fields.exp  = EXP_W'(EXP_MAX);
      special_res.fields.frac = '0;
    end else if (inf_b) begin
      special_res.fields.sign = sign_b;
      special_res.fields.exp  = EXP_W'(EXP_MAX);
      special_res.fields.frac = '0;
    end else begin
      special = 1'b0;
    end
  end

  // larger magnitude goes first
  assign swap       = (exp_b > exp_a) || ((exp_b == exp_a) && (sig_b > sig_a));
  assign exp_big    = swap ? exp_b : exp_a;
  assign exp_diff   = swap ? (exp_b - exp_a) : (exp_a - exp_b);
  assign ext_big    = swap ? {sig_b, {GRS_W{1'b0}}} : {sig_a, {GRS_W{1'b0}}};
  assign ext_small  = swap ? {sig_a, {GRS_W{1'b0}}} : {sig_b, {GRS_W{1'b0}}};
  assign sign_big   = swap ? sign_b : sign_a;
  assign sign_small = swap ? sign_a : sign_b;

  // a shift past the width clears the word, mask then covers all of it
  assign shift_mask = ~({EXT_W{1'b1}} << exp_diff);
  assign sticky     = |(ext_small & shift_mask);
  assign ext_shift  = (ext_small >> exp_diff) | EXT_W'(sticky);

  assign mag = (sign_big == sign_small) ? ({1'b0, ext_big} + {1'b0, ext_shift})
                                        : ({1'b0, ext_big} - {1'b0, ext_shift});

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= enable;
    end
  end

  always_ff @(posedge CLK) begin
    s1_special     <= special;
    s1_special_res <= special_res;
    s1_mag         <= mag;
    s1_exp         <= exp_big;
    s1_sign        <= sign_big;
  end

endmodule

`default_nettype wire

/* rtl/lead_zero_count.sv */
`timescale 1ns/1ns
`default_nettype none

module lead_zero_count
  import vector_pkg::*;
(
  input  logic [SUM_W-1:0] value,
  output logic [LZ_W-1:0]  count
);

  // scan from the lsb up so the highest set bit wins
  always_comb begin
    count = LZ_W'(SUM_W);  // all zeros
    for (int i = 0; i < SUM_W; i++) begin
      if (value[i]) begin
        count = LZ_W'(SUM_W - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

/* common/vector_pkg.sv */
`default_nettype none

package vector_pkg;

  // binary16 field widths
  localparam int EXP_W  = 5;
  localparam int FRAC_W = 10;
  localparam int SIG_W  = FRAC_W + 1;  // hidden bit included
  localparam int GRS_W  = 3;           // guard, round, sticky
  localparam int EXT_W  = SIG_W + GRS_W;
  localparam int SUM_W  = EXT_W + 1;   // room for the adder carry

  localparam int EXP_MAX = 31;         // inf / nan exponent

  // canonical quiet nan, payload is never propagated
  localparam logic [15:0] FP16_QNAN = 16'h7E00;

  // leading-zero count wide enough to hold SUM_W itself
  localparam int LZ_W = 4;

  typedef struct packed {
    logic              sign;
    logic [EXP_W-1:0]  exp;
    logic [FRAC_W-1:0] frac;
  } fp16_fields_t;

  // one word, seen either as raw bits or as decoded fields
  typedef union packed {
    logic [15:0]  raw;
    fp16_fields_t fields;
  } fp16_t;

endpackage

`default_nettype wire
